//--- list.f
+incdir+rtl
rtl/ext_harness_pkg.sv
rtl/obi_fifo.sv
rtl/slow_memory.sv
rtl/switch_ack_delay.sv
rtl/ext_harness.sv
bench/ext_harness_chk.sv
bench/tb_ext_harness.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f list.f \
  --top-module tb_ext_harness \
  -o tb_sim

# the simulator may stop early on an assertion, the search below decides
output=$(./obj_dir/tb_sim 2>&1) || true
echo "$output"

if printf '%s\n' "$output" | grep -qx "Finished with no errors"; then
  exit 0
fi
exit 1

//--- bench/tb_ext_harness.sv
// testbench for ext_harness, reads only words that were written before
// the run is bounded by a cycle limit scaled from the operation count
`timescale 1ns/1ps
`include "ext_harness_settings.svh"

module tb_ext_harness;
  import ext_harness_pkg::*;

  localparam logic [31:0] SEED    = 32'h18e7_231c;
  localparam int          NUM_OPS = 88;
  localparam int          DEPTH   = `OBI_FIFO_DEPTH;
  localparam int          ACK_LAT = `SWITCH_ACK_LATENCY;
  localparam int          TIMEOUT = NUM_OPS * (DEPTH + 1) * (`SLOW_MEM_LATENCY + 1) + 300;

  logic        clk;
  logic        rst_n;
  obi_req_t    obi_req;
  obi_resp_t   obi_resp;
  pwr_switch_t switch_n;
  pwr_switch_t switch_ack_n;

  data_t       ref_mem [`SLOW_MEM_WORDS];
  data_t       exp_q [$];
  addr_t       addrs [16];
  pwr_switch_t sw_hist [32];
  logic [31:0] bus_rng = SEED;
  bit          stim_done = 1'b0;
  int          data_errs = 0;
  int          proto_errs = 0;
  int          switch_errs = 0;
  int          seq_errs = 0;
  int          stalls = 0;
  int          grants = 0;
  int          resps = 0;
  int          cycles = 0;
  int          edge_cnt = 0;
  int          last_rst_edge = -1;

  ext_harness dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .obi_req_i      (obi_req),
    .obi_resp_o     (obi_resp),
    .switch_n_i     (switch_n),
    .switch_ack_n_o (switch_ack_n)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] bus_rand();
    bus_rng = lcg_next(bus_rng);
    return bus_rng;
  endfunction

  // 32 KiB aliasing, word index is addr[14:2]
  function automatic word_idx_t word_of(input addr_t addr);
    return word_idx_t'(addr >> 2);
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t wdata, input be_t be);
    data_t result;
    result = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        result[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return result;
  endfunction

  function automatic data_t expected_read(input addr_t addr);
    return ref_mem[word_of(addr)];
  endfunction

  // hold the request until granted
  task automatic bus_access(input logic we, input be_t be, input addr_t addr, input data_t wdata);
    @(negedge clk);
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    obi_req.be    = be;
    obi_req.addr  = addr;
    obi_req.wdata = wdata;
    @(posedge clk);
    while (!obi_resp.gnt) begin
      @(posedge clk);
    end
  endtask

  task automatic drain();
    @(negedge clk);
    obi_req = '0;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic report_and_finish(input bit timed_out);
    int total;
    total = data_errs + proto_errs + switch_errs + seq_errs;
    if (timed_out) begin
      $display("timeout: the test did not finish within %0d cycles", TIMEOUT);
    end
    $display("errors: data %0d, protocol %0d, switch %0d, sequence %0d (grants %0d)",
             data_errs, proto_errs, switch_errs, seq_errs, grants);
    if (timed_out || total != 0) begin
      $display("Finished with errors");
    end else begin
      $display("Finished with no errors");
    end
    $finish;
  endtask

  // compare process, all DUT outputs sampled before the edge updates them
  always @(posedge clk) begin : compare
    int          out_before;
    data_t       exp_word;
    pwr_switch_t exp_ack;
    if (rst_n) begin
      out_before = exp_q.size();
      if (obi_resp.rvalid) begin
        resps++;
        if (exp_q.size() == 0) begin
          $display("rvalid at %0t with no request outstanding", $time);
          proto_errs++;
        end else begin
          exp_word = exp_q.pop_front();
          if (obi_resp.rdata !== exp_word) begin
            $display("Error at %0t: obi_resp.rdata got %h expected %h",
                     $time, obi_resp.rdata, exp_word);
            data_errs++;
          end
        end
      end
      if (obi_req.req && obi_resp.gnt) begin
        if (out_before > DEPTH) begin
          $display("grant at %0t with %0d accesses already outstanding", $time, out_before);
          proto_errs++;
        end
        if (obi_req.we) begin
          ref_mem[word_of(obi_req.addr)] =
            merge_bytes(ref_mem[word_of(obi_req.addr)], obi_req.wdata, obi_req.be);
          exp_q.push_back('0);
        end else begin
          exp_q.push_back(expected_read(obi_req.addr));
        end
        grants++;
      end else if (obi_req.req) begin
        stalls++;
        if (out_before < DEPTH) begin
          $display("gnt held low at %0t although the FIFO had room", $time);
          proto_errs++;
        end
      end else if (obi_resp.gnt) begin
        $display("gnt high at %0t without a request", $time);
        proto_errs++;
      end
    end
    // acknowledge after the previous edge
    if (last_rst_edge >= 0 && edge_cnt > last_rst_edge) begin
      if (edge_cnt - ACK_LAT <= last_rst_edge) begin
        exp_ack = '1;
      end else begin
        exp_ack = sw_hist[5'(edge_cnt - ACK_LAT)];
      end
      if (switch_ack_n !== exp_ack) begin
        $display("Error at %0t: switch_ack_n got %b expected %b", $time, switch_ack_n, exp_ack);
        switch_errs++;
      end
    end
    sw_hist[5'(edge_cnt)] = switch_n;
    if (!rst_n) begin
      last_rst_edge = edge_cnt;
    end
    edge_cnt++;
  end

  // random switch commands every cycle, also during reset
  initial begin : switch_stim
    logic [31:0] sw_state;
    sw_state = SEED;
    switch_n = '1;
    while (!stim_done) begin
      @(negedge clk);
      sw_state = lcg_next(sw_state);
      switch_n = pwr_switch_t'(sw_state[23:16]);
    end
  end

  initial begin : stimulus
    logic [31:0] r;
    int          stalls_before;
    rst_n   = 1'b0;
    obi_req = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (obi_resp.gnt !== 1'b0) begin
      $display("Error at %0t: obi_resp.gnt got %b expected 0", $time, obi_resp.gnt);
      seq_errs++;
    end
    if (obi_resp.rvalid !== 1'b0) begin
      $display("Error at %0t: obi_resp.rvalid got %b expected 0", $time, obi_resp.rvalid);
      seq_errs++;
    end
    // full words first, so every later read is defined
    for (int i = 0; i < 16; i++) begin
      r = bus_rand();
      addrs[4'(i)] = {r[31:2], 2'b00};
      bus_access(1'b1, 4'hf, addrs[4'(i)], bus_rand());
    end
    for (int i = 0; i < 16; i++) begin
      r = bus_rand();
      bus_access(1'b1, r[3:0], addrs[r[7:4]], bus_rand());
    end
    for (int i = 0; i < 16; i++) begin
      bus_access(1'b0, 4'hf, addrs[4'(i)], '0);
    end
    // write 32 KiB up, read back 64 KiB away
    for (int i = 0; i < 8; i++) begin
      bus_access(1'b1, 4'hf, addrs[4'(i)] + 32'h0000_8000, bus_rand());
      bus_access(1'b0, 4'hf, addrs[4'(i)] ^ 32'h0001_0000, '0);
    end
    drain();
    stalls_before = stalls;
    for (int i = 0; i < 24; i++) begin
      r = bus_rand();
      bus_access(r[8], r[3:0], addrs[r[7:4]], bus_rand());
    end
    drain();
    if (stalls == stalls_before) begin
      $display("the FIFO never filled during the back-to-back burst");
      seq_errs++;
    end
    repeat (ACK_LAT + 2) @(negedge clk);
    // one rvalid per request, none extra after the queue emptied
    if (resps != NUM_OPS) begin
      $display("Error at %0t: obi_resp.rvalid count got %0d expected %0d",
               $time, resps, NUM_OPS);
      seq_errs++;
    end
    stim_done = 1'b1;
    report_and_finish(1'b0);
  end

  initial begin : watchdog
    while (cycles < TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    report_and_finish(1'b1);
  end

endmodule

//--- bench/ext_harness_chk.sv
// protocol and switch-timing assertions, bound into ext_harness
// the acknowledge check starts once SWITCH_ACK_LATENCY edges have passed out of reset
`timescale 1ns/1ps
`include "ext_harness_settings.svh"

module ext_harness_chk (
  input logic                         clk_i,
  input logic                         rst_n_i,
  input ext_harness_pkg::obi_req_t    obi_req_i,
  input ext_harness_pkg::obi_resp_t   obi_resp_o,
  input ext_harness_pkg::pwr_switch_t switch_n_i,
  input ext_harness_pkg::pwr_switch_t switch_ack_n_o
);

  localparam int unsigned ACK_LAT = `SWITCH_ACK_LATENCY;

  logic        granted;
  int unsigned outstanding_q;
  int unsigned since_rst_q;

  assign granted = obi_req_i.req && obi_resp_o.gnt;

  // grants not yet answered, and edges since reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      outstanding_q <= 0;
      since_rst_q   <= 0;
    end else begin
      outstanding_q <= outstanding_q + 32'(granted) - 32'(obi_resp_o.rvalid);
      if (since_rst_q < ACK_LAT) begin
        since_rst_q <= since_rst_q + 1;
      end
    end
  end

  rvalid_after_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    obi_resp_o.rvalid |-> outstanding_q != 0)
    else $error("rvalid seen with no outstanding grant");

  ack_follows_switch: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (since_rst_q >= ACK_LAT) |-> switch_ack_n_o == $past(switch_n_i, ACK_LAT))
    else $error("switch acknowledge does not match the delayed command");

  // initiator holds a pending request unchanged
  req_held_until_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (obi_req_i.req && !obi_resp_o.gnt) |=> $stable(obi_req_i))
    else $error("request changed before it was granted");

endmodule

bind ext_harness ext_harness_chk u_chk (
  .clk_i          (clk_i),
  .rst_n_i        (rst_n_i),
  .obi_req_i      (obi_req_i),
  .obi_resp_o     (obi_resp_o),
  .switch_n_i     (switch_n_i),
  .switch_ack_n_o (switch_ack_n_o)
);

//--- rtl/ext_harness.sv
// external bus slow memory behind a request FIFO, plus the switch-cell model
// bus latency depends on queue occupancy, rvalid marks the end of each access
`timescale 1ns/1ps

module ext_harness (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  ext_harness_pkg::obi_req_t    obi_req_i,
  output ext_harness_pkg::obi_resp_t   obi_resp_o,
  input  ext_harness_pkg::pwr_switch_t switch_n_i,
  output ext_harness_pkg::pwr_switch_t switch_ack_n_o
);
  import ext_harness_pkg::*;

  // FIFO to memory link
  obi_req_t  mem_req;
  obi_resp_t mem_resp;

  // queue in front of the memory, adds latency on purpose
  obi_fifo u_obi_fifo (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .producer_req_i  (obi_req_i),
    .producer_resp_o (obi_resp_o),
    .consumer_req_o  (mem_req),
    .consumer_resp_i (mem_resp)
  );

  slow_memory u_slow_memory (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (mem_req),
    .resp_o  (mem_resp)
  );

  // power-gate acknowledges
  switch_ack_delay u_switch_ack_delay (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .switch_n_i     (switch_n_i),
    .switch_ack_n_o (switch_ack_n_o)
  );

endmodule

//--- rtl/switch_ack_delay.sv
// stands in for the power-switch cells, every command returns as its acknowledge
// acknowledges read all ones during reset and for SWITCH_ACK_LATENCY cycles after
`timescale 1ns/1ps
`include "ext_harness_settings.svh"

module switch_ack_delay (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  ext_harness_pkg::pwr_switch_t switch_n_i,
  output ext_harness_pkg::pwr_switch_t switch_ack_n_o
);
  import ext_harness_pkg::*;

  localparam int unsigned STAGES = `SWITCH_ACK_LATENCY;

  pwr_switch_t stage_q [STAGES];

  // one stage per cycle of switch ramp-up
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < STAGES; i++) begin
        // switches off, so no acknowledge
        stage_q[i] <= '1;
      end
    end else begin
      stage_q[0] <= switch_n_i;
      for (int i = 1; i < STAGES; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign switch_ack_n_o = stage_q[STAGES-1];

endmodule

//--- rtl/slow_memory.sv
// word memory answering SLOW_MEM_LATENCY cycles after each grant, one access at a time
// address bits above 14 are ignored, so the contents alias every 32 KiB
`timescale 1ns/1ps
`include "ext_harness_settings.svh"

module slow_memory (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  ext_harness_pkg::obi_req_t  req_i,
  output ext_harness_pkg::obi_resp_t resp_o
);
  import ext_harness_pkg::*;

  localparam int unsigned LATENCY = `SLOW_MEM_LATENCY;
  localparam int unsigned CNT_W   = $clog2(LATENCY + 1);
  localparam int unsigned IDX_LSB = 2;

  typedef enum logic {
    IDLE,
    BUSY
  } mem_state_e;

  data_t      mem_q [`SLOW_MEM_WORDS];
  mem_state_e state_q;
  logic [CNT_W-1:0] cnt_q;
  logic       rvalid_q;
  data_t      rdata_q;
  word_idx_t  word_idx;
  logic       gnt;

  // word select, upper address bits dropped
  assign word_idx = req_i.addr[IDX_LSB +: $bits(word_idx_t)];

  // only one access in flight
  assign gnt = req_i.req && (state_q == IDLE);

  always_comb begin
    resp_o.gnt    = gnt;
    resp_o.rvalid = rvalid_q;
    resp_o.rdata  = rdata_q;
  end

  // storage with byte enables
  always_ff @(posedge clk_i) begin
    if (gnt && req_i.we) begin
      for (int i = 0; i < $bits(be_t); i++) begin
        if (req_i.be[i]) begin
          mem_q[word_idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
        end
      end
    end
  end

  // read word captured at grant, writes answer with zero
  always_ff @(posedge clk_i) begin
    if (gnt) begin
      rdata_q <= req_i.we ? '0 : mem_q[word_idx];
    end
  end

  // latency counter, rvalid lands in the cycle the FSM is back in IDLE
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= IDLE;
      cnt_q    <= '0;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= 1'b0;
      case (state_q)
        IDLE: begin
          if (gnt) begin
            state_q <= BUSY;
            cnt_q   <= CNT_W'(LATENCY - 1);
          end
        end
        BUSY: begin
          if (cnt_q == CNT_W'(1)) begin
            state_q  <= IDLE;
            rvalid_q <= 1'b1;
          end
          cnt_q <= cnt_q - CNT_W'(1);
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- rtl/obi_fifo.sv
// request queue between an OBI initiator and a single target
// responses are not buffered, the target must return them in grant order
`timescale 1ns/1ps
`include "ext_harness_settings.svh"

module obi_fifo (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  ext_harness_pkg::obi_req_t  producer_req_i,
  output ext_harness_pkg::obi_resp_t producer_resp_o,
  output ext_harness_pkg::obi_req_t  consumer_req_o,
  input  ext_harness_pkg::obi_resp_t consumer_resp_i
);
  import ext_harness_pkg::*;

  localparam int unsigned DEPTH = `OBI_FIFO_DEPTH;
  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  obi_req_t         entries [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // circular pointer advance
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + PTR_W'(1);
  endfunction

  assign full  = (count_q == CNT_W'(DEPTH));
  assign empty = (count_q == '0);

  // accept whenever a slot is free
  assign push = producer_req_i.req && !full;
  assign pop  = consumer_req_o.req && consumer_resp_i.gnt;

  // responses go straight back to the producer
  always_comb begin
    producer_resp_o.gnt    = push;
    producer_resp_o.rvalid = consumer_resp_i.rvalid;
    producer_resp_o.rdata  = consumer_resp_i.rdata;
  end

  // head entry, valid only while something is queued
  always_comb begin
    consumer_req_o     = entries[rd_ptr_q];
    consumer_req_o.req = !empty;
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      entries[wr_ptr_q] <= producer_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // occupancy, unchanged on simultaneous push and pop
      case ({push, pop})
        2'b10: begin
          count_q <= count_q + CNT_W'(1);
        end
        2'b01: begin
          count_q <= count_q - CNT_W'(1);
        end
        default: begin
          count_q <= count_q;
        end
      endcase
    end
  end

endmodule

//--- rtl/ext_harness_pkg.sv
// bus and power-switch types shared by the harness blocks
// field widths follow the settings header
`include "ext_harness_settings.svh"

package ext_harness_pkg;

  // byte address on the external bus
  typedef logic [31:0] addr_t;

  // one bus data word
  typedef logic [31:0] data_t;

  // one enable per byte lane
  typedef logic [3:0] be_t;

  // index into the slow memory
  typedef logic [$clog2(`SLOW_MEM_WORDS)-1:0] word_idx_t;

  // OBI request, held by the initiator until granted
  typedef struct packed {
    logic  req;
    logic  we;
    be_t   be;
    addr_t addr;
    data_t wdata;
  } obi_req_t;

  // OBI response, gnt is combinational and rvalid one cycle per grant
  typedef struct packed {
    logic  gnt;
    logic  rvalid;
    data_t rdata;
  } obi_resp_t;

  // power-gate switch lines, all active low
  // same layout for commands and acknowledges
  typedef struct packed {
    logic                    cpu;
    logic                    periph;
    logic [`NUM_BANKS-1:0]   mem_banks;
    logic [`EXT_DOMAINS-1:0] ext;
  } pwr_switch_t;

endpackage

//--- rtl/ext_harness_settings.svh
// build-time settings for the external harness
// SLOW_MEM_LATENCY must be at least 2 and SLOW_MEM_WORDS a power of two
`ifndef EXT_HARNESS_SETTINGS_SVH
`define EXT_HARNESS_SETTINGS_SVH

// cycles from a power-switch command to its acknowledge
`define SWITCH_ACK_LATENCY 15

// power domains driven by the switch commands
`define NUM_BANKS 4
`define EXT_DOMAINS 2

// request slots between the bus port and the memory
`define OBI_FIFO_DEPTH 2

// slow memory geometry and timing
`define SLOW_MEM_WORDS 8192

// cycles from memory grant to rvalid
`define SLOW_MEM_LATENCY 4

`endif
